//--- compile.f
+incdir+bench
src/regex_pkg.sv
src/regex_bram.sv
src/regex_command_ctrl.sv
src/regex_coprocessor.sv
src/regex_system_top.sv
bench/regex_tb.sv

//--- run_sim.sh
#!/bin/bash
# builds the regex testbench with Verilator, runs it, then scans the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns --top-module regex_tb \
    -f compile.f -o regex_tb_sim > build.log 2>&1 \
    && ./obj_dir/regex_tb_sim > "$LOG" 2>&1 \
    && cat "$LOG" \
    || { echo "build or simulation did not complete, see build.log and $LOG"; exit 1; }

grep -q "Testbench failed" "$LOG" \
    && { echo "simulation reported a failure"; exit 1; } \
    || { echo "simulation finished without a failure"; exit 0; }

//--- bench/regex_tb_tasks.svh
//////////////////////////////////////////////////////////////////////
// command port drivers
//////////////////////////////////////////////////////////////////////

// new register values just after the edge
task automatic drive_command(input cmd_e cmd, input logic [REG_WIDTH-1:0] address,
                             input logic [REG_WIDTH-1:0] data_in);
    @(posedge clk);
    #1;
    regs.cmd     = cmd;
    regs.address = address;
    regs.data_in = data_in;
endtask

task automatic read_word(input logic [REG_WIDTH-1:0] address,
                         output logic [REG_WIDTH-1:0] value);
    drive_command(CMD_READ, address, '0);
    @(posedge clk);         // read port is registered
    @(negedge clk);
    value = data_out;
endtask

task automatic read_elapsed(output logic [REG_WIDTH-1:0] value);
    drive_command(CMD_READ_ELAPSED, '0, '0);
    @(negedge clk);
    value = data_out;       // combinational under this command
endtask

//////////////////////////////////////////////////////////////////////
// program image
//////////////////////////////////////////////////////////////////////

function automatic instr_t make_instr(input logic [7:0] opcode, input logic [7:0] operand);
    return instr_t'({opcode, operand});
endfunction

function automatic void clear_image();
    for (int i = 0; i < IMAGE_BYTES; i++)
        image[i] = 8'h00;
endfunction

// instruction i at byte 2i with its operand in the low byte
function automatic void put_instr(input int index, input instr_t ins);
    image[2*index]   = ins.operand;
    image[2*index+1] = ins.opcode;
endfunction

function automatic void put_text(input string text);
    for (int k = 0; k < text.len(); k++)
        image[TEXT_BASE+k] = text[k];
    image[TEXT_BASE+text.len()] = 8'h00;        // terminator
endfunction

// byte k of a write word at bits 8k
function automatic logic [REG_WIDTH-1:0] image_word(input int w);
    return {image[4*w+3], image[4*w+2], image[4*w+1], image[4*w]};
endfunction

function automatic void build_literal_program();
    clear_image();
    put_instr(0, make_instr(OP_CHAR, "a"));
    put_instr(1, make_instr(OP_CHAR, "b"));
    put_instr(2, make_instr(OP_CHAR, "c"));
    put_instr(3, make_instr(OP_END, 8'h00));
endfunction

task automatic load_image();
    for (int w = 0; w < IMAGE_WORDS; w++)
        drive_command(CMD_WRITE, w, image_word(w));
    drive_command(CMD_NOP, '0, '0);
endtask

//////////////////////////////////////////////////////////////////////
// compare and report
//////////////////////////////////////////////////////////////////////

task automatic check_status(input string what, input status_e got, input status_e expected);
    if (got !== expected)
    begin
        $display("FAILED at %0t ns: %s, status %s, expected %s",
                 $time, what, got.name(), expected.name());
        error_count++;
    end
endtask

task automatic check_word(input string what, input logic [REG_WIDTH-1:0] got,
                          input logic [REG_WIDTH-1:0] expected);
    if (got !== expected)
    begin
        $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
        error_count++;
    end
endtask

task automatic expect_true(input string what, input bit ok);
    if (!ok)
    begin
        $display("FAILED at %0t ns: %s", $time, what);
        error_count++;
    end
endtask

task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (error_count > errors_before)
    begin
        tests_failed++;
        $display("test %s: failed with %0d mismatches", name, error_count - errors_before);
    end
    else
    begin
        $display("test %s: ok", name);
    end
endtask

//////////////////////////////////////////////////////////////////////
// runs
//////////////////////////////////////////////////////////////////////

task automatic run_program(input string name, input status_e expected);
    bit finished;
    finished = 1'b0;
    drive_command(CMD_START, '0, '0);
    drive_command(CMD_NOP, '0, '0);
    for (int n = 0; n < RUN_BOUND && !finished; n++)
    begin
        @(negedge clk);
        finished = (status != STATUS_IDLE) && (status != STATUS_RUNNING);
    end
    if (!finished)
    begin
        $display("%s: the run did not finish within %0d cycles", name, RUN_BOUND);
        error_count++;
    end
    else
    begin
        check_status(name, status, expected);
    end
endtask

task automatic restart_run();
    drive_command(CMD_RESTART, '0, '0);
    drive_command(CMD_NOP, '0, '0);
    @(negedge clk);
    check_status("restart", status, STATUS_IDLE);
endtask

task automatic read_back_random(input string what);
    logic [REG_WIDTH-1:0] got;
    for (int i = 0; i < RAND_COUNT; i++)
    begin
        read_word(RAND_BASE + i, got);
        check_word(what, got, rand_words[i]);
    end
endtask

//////////////////////////////////////////////////////////////////////
// tests
//////////////////////////////////////////////////////////////////////

task automatic test_mem_rw();
    int errors_before;
    errors_before = error_count;
    for (int i = 0; i < RAND_COUNT; i++)
    begin
        rand_words[i] = $urandom;
        drive_command(CMD_WRITE, RAND_BASE + i, rand_words[i]);
    end
    drive_command(CMD_NOP, '0, '0);
    read_back_random("memory read");        // even and odd words hit both halves
    finish_test("memory_rw", errors_before);
endtask

task automatic test_literal();
    int errors_before;
    errors_before = error_count;
    build_literal_program();
    put_text("abc");
    load_image();
    run_program("literal abc", STATUS_ACCEPTED);
    restart_run();
    put_text("abd");
    load_image();
    run_program("literal abd", STATUS_REJECTED);
    restart_run();
    finish_test("literal", errors_before);
endtask

task automatic test_wildcard();
    int errors_before;
    errors_before = error_count;
    clear_image();
    put_instr(0, make_instr(OP_CHAR, "x"));
    put_instr(1, make_instr(OP_JUMP, 8'd3));
    put_instr(2, make_instr(8'h7F, 8'h00));     // skipped by the jump
    put_instr(3, make_instr(OP_ANY, 8'h00));
    put_instr(4, make_instr(OP_ACCEPT, 8'h00));
    put_text("xy");
    load_image();
    run_program("wildcard xy", STATUS_ACCEPTED);
    restart_run();
    put_text("x");                              // terminator where any needs a char
    load_image();
    run_program("wildcard x", STATUS_REJECTED);
    restart_run();
    finish_test("wildcard_jump", errors_before);
endtask

task automatic test_illegal();
    int errors_before;
    errors_before = error_count;
    clear_image();
    put_instr(0, make_instr(8'h7F, 8'h00));
    put_text("a");
    load_image();
    run_program("illegal opcode", STATUS_ERROR);
    restart_run();
    finish_test("illegal_opcode", errors_before);
endtask

task automatic test_elapsed();
    int                   errors_before;
    logic [REG_WIDTH-1:0] short_count;
    logic [REG_WIDTH-1:0] later_count;
    logic [REG_WIDTH-1:0] long_count;
    errors_before = error_count;
    clear_image();
    put_instr(0, make_instr(OP_ACCEPT, 8'h00));
    load_image();
    run_program("accept only", STATUS_ACCEPTED);
    read_elapsed(short_count);
    expect_true("elapsed count is zero after a finished run", short_count != 0);
    drive_command(CMD_NOP, '0, '0);
    repeat (20) @(posedge clk);                 // count must hold while idle
    read_elapsed(later_count);
    check_word("elapsed count while idle", later_count, short_count);
    restart_run();
    build_literal_program();
    put_text("abc");
    load_image();
    run_program("longer program", STATUS_ACCEPTED);
    read_elapsed(long_count);
    expect_true("longer program did not give a larger elapsed count",
                long_count > short_count);
    restart_run();
    finish_test("elapsed", errors_before);
endtask

task automatic test_soft_reset();
    int                   errors_before;
    logic [REG_WIDTH-1:0] count;
    logic [REG_WIDTH-1:0] got;
    errors_before = error_count;
    build_literal_program();
    put_text("abc");
    load_image();
    run_program("before soft reset", STATUS_ACCEPTED);
    drive_command(CMD_RESET, '0, '0);
    drive_command(CMD_NOP, '0, '0);
    @(negedge clk);
    check_status("after soft reset", status, STATUS_IDLE);
    read_elapsed(count);
    check_word("elapsed count after soft reset", count, '0);
    read_back_random("random word after soft reset");
    for (int w = 0; w < IMAGE_WORDS; w++)
    begin
        read_word(w, got);
        check_word("image word after soft reset", got, image_word(w));
    end
    drive_command(CMD_NOP, '0, '0);
    finish_test("soft_reset", errors_before);
endtask

//--- bench/regex_tb.sv
`timescale 1ns/1ns

module regex_tb;

    import regex_pkg::*;

    localparam int TEST_CYCLES = 1500;                      // rough upper estimate for all tests
    localparam int MAX_CYCLES  = TEST_CYCLES * 2 + 1000;    // margin on top
    localparam int RUN_BOUND   = 300;                       // polling limit per program run
    localparam int IMAGE_BYTES = 128;                       // program plus text
    localparam int IMAGE_WORDS = IMAGE_BYTES / 4;
    localparam int TEXT_BASE   = 64;                        // text starts at this byte
    localparam int RAND_BASE   = 100;                       // write words for the memory test
    localparam int RAND_COUNT  = 16;

    logic                 clk;
    logic                 reset_master;
    cmd_regs_t            regs;
    status_e              status;
    logic [REG_WIDTH-1:0] data_out;

    int                   cycle_count = 0;
    int                   error_count;
    int                   tests_run;
    int                   tests_failed;
    logic [7:0]           image [IMAGE_BYTES];      // byte image of program and text
    logic [REG_WIDTH-1:0] rand_words [RAND_COUNT];

    regex_system_top #(
        .READ_WIDTH       (64),
        .READ_ADDR_WIDTH  (9),
        .WRITE_WIDTH      (32),
        .WRITE_ADDR_WIDTH (10)
    ) dut (
        .clk          (clk),
        .reset_master (reset_master),
        .regs         (regs),
        .status       (status),
        .data_out     (data_out)
    );

    `include "regex_tb_tasks.svh"

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run length guard
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("timeout: simulation ran past %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(64));
        error_count           = 0;
        tests_run             = 0;
        tests_failed          = 0;
        regs.cmd              = CMD_NOP;
        regs.address          = '0;
        regs.data_in          = '0;
        regs.start_cc_pointer = TEXT_BASE;      // text always at the same place
        reset_master          = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset_master = 1'b0;

        test_mem_rw();
        test_literal();
        test_wildcard();
        test_illegal();
        test_elapsed();
        test_soft_reset();

        repeat (5) @(posedge clk);
        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- src/regex_system_top.sv
`timescale 1ns/1ns

module regex_system_top #(
    parameter int READ_WIDTH       = 64,
    parameter int READ_ADDR_WIDTH  = 9,
    parameter int WRITE_WIDTH      = 32,
    parameter int WRITE_ADDR_WIDTH = 10
) (
    input  logic                            clk,
    input  logic                            reset_master,
    input  regex_pkg::cmd_regs_t            regs,
    output regex_pkg::status_e              status,
    output logic [regex_pkg::REG_WIDTH-1:0] data_out
);

    import regex_pkg::*;

    logic                        core_reset;     // hard reset or soft reset command
    logic [READ_ADDR_WIDTH-1:0]  bram_r_addr;
    logic                        bram_r_valid;
    logic [READ_WIDTH-1:0]       bram_r_data;
    logic [WRITE_ADDR_WIDTH-1:0] bram_w_addr;
    logic [WRITE_WIDTH-1:0]      bram_w_data;
    logic                        bram_w_en;
    logic                        mem_req_valid;
    logic [READ_ADDR_WIDTH-1:0]  mem_req_addr;
    logic                        mem_req_ready;
    logic [READ_WIDTH-1:0]       mem_rsp_data;
    logic                        start_valid;
    logic                        start_ready;
    logic                        result_valid;
    coproc_result_t              result;

    regex_command_ctrl #(
        .READ_WIDTH       (READ_WIDTH),
        .READ_ADDR_WIDTH  (READ_ADDR_WIDTH),
        .WRITE_WIDTH      (WRITE_WIDTH),
        .WRITE_ADDR_WIDTH (WRITE_ADDR_WIDTH)
    ) u_ctrl (
        .clk           (clk),
        .reset_master  (reset_master),
        .regs          (regs),
        .status        (status),
        .data_out      (data_out),
        .core_reset    (core_reset),
        .bram_r_addr   (bram_r_addr),
        .bram_r_valid  (bram_r_valid),
        .bram_r_data   (bram_r_data),
        .bram_w_addr   (bram_w_addr),
        .bram_w_data   (bram_w_data),
        .bram_w_en     (bram_w_en),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_data  (mem_rsp_data),
        .start_valid   (start_valid),
        .start_ready   (start_ready),
        .result_valid  (result_valid),
        .result        (result)
    );

    // program and text share this memory
    regex_bram #(
        .READ_WIDTH       (READ_WIDTH),
        .READ_ADDR_WIDTH  (READ_ADDR_WIDTH),
        .WRITE_WIDTH      (WRITE_WIDTH),
        .WRITE_ADDR_WIDTH (WRITE_ADDR_WIDTH)
    ) u_bram (
        .clk          (clk),
        .reset_master (core_reset),
        .r_addr       (bram_r_addr),
        .r_valid      (bram_r_valid),
        .r_data       (bram_r_data),
        .w_addr       (bram_w_addr),
        .w_data       (bram_w_data),
        .w_en         (bram_w_en)
    );

    regex_coprocessor #(
        .READ_WIDTH      (READ_WIDTH),
        .READ_ADDR_WIDTH (READ_ADDR_WIDTH)
    ) u_coproc (
        .clk              (clk),
        .reset_master     (core_reset),
        .start_valid      (start_valid),
        .start_ready      (start_ready),
        .start_cc_pointer (regs.start_cc_pointer),
        .mem_req_valid    (mem_req_valid),
        .mem_req_addr     (mem_req_addr),
        .mem_req_ready    (mem_req_ready),
        .mem_rsp_data     (mem_rsp_data),
        .result_valid     (result_valid),
        .result           (result)
    );

endmodule

//--- src/regex_coprocessor.sv
`timescale 1ns/1ns

module regex_coprocessor #(
    parameter int READ_WIDTH      = 64,
    parameter int READ_ADDR_WIDTH = 9
) (
    input  logic                              clk,
    input  logic                              reset_master,
    input  logic                              start_valid,
    output logic                              start_ready,
    input  logic [regex_pkg::REG_WIDTH-1:0]   start_cc_pointer,
    output logic                              mem_req_valid,
    output logic [READ_ADDR_WIDTH-1:0]        mem_req_addr,
    input  logic                              mem_req_ready,
    input  logic [READ_WIDTH-1:0]             mem_rsp_data,
    output logic                              result_valid,
    output regex_pkg::coproc_result_t         result
);

    import regex_pkg::*;

    localparam int BYTE_SEL        = $clog2(READ_WIDTH / 8);       // byte within read word
    localparam int BYTE_ADDR_WIDTH = READ_ADDR_WIDTH + BYTE_SEL;
    localparam int INSTR_WIDTH     = $bits(instr_t);

    typedef enum logic [2:0] {
        IDLE,
        FETCH_INSTR,
        WAIT_INSTR,
        FETCH_CHAR,
        WAIT_CHAR,
        EXECUTE,
        DONE
    } state_e;

    state_e                     state;
    logic [7:0]                 pc;
    logic [BYTE_ADDR_WIDTH-1:0] cc;             // text byte pointer
    logic [BYTE_ADDR_WIDTH-1:0] instr_byte;     // byte address of instruction pc
    instr_t                     instr;
    instr_t                     fetched_instr;
    logic [7:0]                 ch;
    logic [7:0]                 fetched_char;
    logic                       exec_step;
    logic                       exec_jump;
    coproc_result_t             exec_res;

    assign instr_byte = BYTE_ADDR_WIDTH'({pc, 1'b0});

    //////////////////////////////////////////////////////////////////////
    // memory requests and response slicing
    //////////////////////////////////////////////////////////////////////

    assign start_ready   = (state == IDLE);
    assign result_valid  = (state == DONE);
    assign mem_req_valid = (state == FETCH_INSTR) || (state == FETCH_CHAR);
    assign mem_req_addr  = (state == FETCH_INSTR) ? instr_byte[BYTE_ADDR_WIDTH-1:BYTE_SEL]
                                                  : cc[BYTE_ADDR_WIDTH-1:BYTE_SEL];

    assign fetched_instr = instr_t'(mem_rsp_data[instr_byte[BYTE_SEL-1:0]*8 +: INSTR_WIDTH]);
    assign fetched_char  = mem_rsp_data[cc[BYTE_SEL-1:0]*8 +: 8];

    always_ff @(posedge clk)
    begin
        if (state == WAIT_INSTR)
            instr <= fetched_instr;
        if (state == WAIT_CHAR)
            ch <= fetched_char;
    end

    // opcode decode
    always_comb
    begin
        exec_step = 1'b0;       // go on with next instruction
        exec_jump = 1'b0;
        exec_res  = '0;
        case (instr.opcode)
            OP_CHAR:   exec_step = (ch == instr.operand);
            OP_ANY:    exec_step = (ch != TERMINATOR);
            OP_JUMP:   exec_jump = 1'b1;
            OP_ACCEPT: exec_res.accept = 1'b1;
            OP_END:    exec_res.accept = (ch == TERMINATOR);
            default:   exec_res.error = 1'b1;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // engine FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset_master)
        begin
            state  <= IDLE;
            pc     <= '0;
            cc     <= '0;
            result <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (start_valid)
                    begin
                        cc    <= start_cc_pointer[BYTE_ADDR_WIDTH-1:0];
                        pc    <= '0;
                        state <= FETCH_INSTR;
                    end
                end
                FETCH_INSTR:
                begin
                    if (mem_req_ready)
                        state <= WAIT_INSTR;
                end
                WAIT_INSTR:
                begin
                    // jump and accept never look at the text
                    if ((fetched_instr.opcode == OP_JUMP) || (fetched_instr.opcode == OP_ACCEPT))
                        state <= EXECUTE;
                    else
                        state <= FETCH_CHAR;
                end
                FETCH_CHAR:
                begin
                    if (mem_req_ready)
                        state <= WAIT_CHAR;
                end
                WAIT_CHAR:
                begin
                    state <= EXECUTE;
                end
                EXECUTE:
                begin
                    if (exec_jump)
                    begin
                        pc    <= instr.operand;
                        state <= FETCH_INSTR;
                    end
                    else if (exec_step)
                    begin
                        pc    <= pc + 1'b1;
                        cc    <= cc + 1'b1;
                        state <= FETCH_INSTR;
                    end
                    else
                    begin
                        result <= exec_res;
                        state  <= DONE;
                    end
                end
                default:
                begin
                    state <= IDLE;      // DONE lasts a single cycle
                end
            endcase
        end
    end

endmodule

//--- src/regex_command_ctrl.sv
`timescale 1ns/1ns

module regex_command_ctrl #(
    parameter int READ_WIDTH       = 64,
    parameter int READ_ADDR_WIDTH  = 9,
    parameter int WRITE_WIDTH      = 32,
    parameter int WRITE_ADDR_WIDTH = 10
) (
    input  logic                              clk,
    input  logic                              reset_master,
    input  regex_pkg::cmd_regs_t              regs,
    output regex_pkg::status_e                status,
    output logic [regex_pkg::REG_WIDTH-1:0]   data_out,
    output logic                              core_reset,
    // memory ports
    output logic [READ_ADDR_WIDTH-1:0]        bram_r_addr,
    output logic                              bram_r_valid,
    input  logic [READ_WIDTH-1:0]             bram_r_data,
    output logic [WRITE_ADDR_WIDTH-1:0]       bram_w_addr,
    output logic [WRITE_WIDTH-1:0]            bram_w_data,
    output logic                              bram_w_en,
    // coprocessor side
    input  logic                              mem_req_valid,
    input  logic [READ_ADDR_WIDTH-1:0]        mem_req_addr,
    output logic                              mem_req_ready,
    output logic [READ_WIDTH-1:0]             mem_rsp_data,
    output logic                              start_valid,
    input  logic                              start_ready,
    input  logic                              result_valid,
    input  regex_pkg::coproc_result_t         result
);

    import regex_pkg::*;

    localparam int SEL_WIDTH = $clog2(READ_WIDTH / WRITE_WIDTH);   // half select bits

    status_e                status_next;
    logic [REG_WIDTH-1:0]   elapsed;
    logic [SEL_WIDTH-1:0]   rd_sel;         // which half of the read word
    logic                   host_owns;      // command port may touch memory
    logic                   cop_owns;       // read port lent to coprocessor
    logic                   cmd_read_en;
    logic                   start_xfer;

    assign core_reset = reset_master || (regs.cmd == CMD_RESET);

    //////////////////////////////////////////////////////////////////////
    // command decode and read port ownership
    //////////////////////////////////////////////////////////////////////

    assign host_owns   = (status != STATUS_RUNNING);
    assign start_valid = (status == STATUS_IDLE) && (regs.cmd == CMD_START);
    assign start_xfer  = start_valid && start_ready;
    assign cop_owns    = (status == STATUS_RUNNING) || start_valid;
    assign cmd_read_en = host_owns && (regs.cmd == CMD_READ);

    assign mem_req_ready = cop_owns;
    assign mem_rsp_data  = bram_r_data;     // coprocessor sees every read word

    assign bram_r_addr  = cop_owns ? mem_req_addr
                                   : regs.address[SEL_WIDTH +: READ_ADDR_WIDTH];
    assign bram_r_valid = cop_owns ? mem_req_valid : cmd_read_en;

    // writes allowed in every state but RUNNING
    assign bram_w_en   = host_owns && (regs.cmd == CMD_WRITE);
    assign bram_w_addr = regs.address[WRITE_ADDR_WIDTH-1:0];
    assign bram_w_data = regs.data_in[WRITE_WIDTH-1:0];

    // read data arrives a cycle late, so the half select is delayed too
    always_ff @(posedge clk)
    begin
        rd_sel <= regs.address[SEL_WIDTH-1:0];
    end

    always_comb
    begin
        data_out = '0;
        if (regs.cmd == CMD_READ_ELAPSED)
            data_out = elapsed;
        else if (cmd_read_en)
            data_out = REG_WIDTH'(bram_r_data[rd_sel*WRITE_WIDTH +: WRITE_WIDTH]);
    end

    //////////////////////////////////////////////////////////////////////
    // status FSM
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        status_next = status;
        case (status)
            STATUS_IDLE:
            begin
                if (start_xfer)
                    status_next = STATUS_RUNNING;
            end
            STATUS_RUNNING:
            begin
                if (result_valid)
                begin
                    if (result.error)
                        status_next = STATUS_ERROR;    // error wins over accept
                    else if (result.accept)
                        status_next = STATUS_ACCEPTED;
                    else
                        status_next = STATUS_REJECTED;
                end
            end
            STATUS_ACCEPTED, STATUS_REJECTED, STATUS_ERROR:
            begin
                if (regs.cmd == CMD_RESTART)
                    status_next = STATUS_IDLE;
            end
            default:
            begin
                status_next = STATUS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (core_reset)
        begin
            status  <= STATUS_IDLE;
            elapsed <= '0;
        end
        else
        begin
            status <= status_next;
            if (start_xfer)
                elapsed <= '0;                  // fresh count per run
            else if ((status == STATUS_RUNNING) && !(&elapsed))
                elapsed <= elapsed + 1'b1;      // saturates at all ones
        end
    end

endmodule

//--- src/regex_bram.sv
`timescale 1ns/1ns

module regex_bram #(
    parameter int READ_WIDTH       = 64,
    parameter int READ_ADDR_WIDTH  = 9,
    parameter int WRITE_WIDTH      = 32,
    parameter int WRITE_ADDR_WIDTH = 10
) (
    input  logic                        clk,
    input  logic                        reset_master,
    input  logic [READ_ADDR_WIDTH-1:0]  r_addr,
    input  logic                        r_valid,
    output logic [READ_WIDTH-1:0]       r_data,
    input  logic [WRITE_ADDR_WIDTH-1:0] w_addr,
    input  logic [WRITE_WIDTH-1:0]      w_data,
    input  logic                        w_en
);

    localparam int RATIO = READ_WIDTH / WRITE_WIDTH;   // write words per read word
    localparam int DEPTH = 2 ** WRITE_ADDR_WIDTH;

    logic [WRITE_WIDTH-1:0] mem [DEPTH];

    // one full word per write
    always_ff @(posedge clk)
    begin
        if (w_en)
            mem[w_addr] <= w_data;
    end

    // lowest write word lands in the low bits of the read word
    always_ff @(posedge clk)
    begin
        if (reset_master)
        begin
            r_data <= '0;
        end
        else if (r_valid)
        begin
            for (int k = 0; k < RATIO; k++)
                r_data[k*WRITE_WIDTH +: WRITE_WIDTH] <= mem[WRITE_ADDR_WIDTH'(r_addr * RATIO + k)];
        end
    end

endmodule

//--- src/regex_pkg.sv
package regex_pkg;

    localparam int REG_WIDTH = 32;          // every host register

    localparam logic [7:0] TERMINATOR = 8'h00;   // end of text

    // host command register
    typedef enum logic [REG_WIDTH-1:0] {
        CMD_NOP          = 'd0,
        CMD_WRITE,
        CMD_READ,
        CMD_START,
        CMD_RESTART,
        CMD_READ_ELAPSED,
        CMD_RESET
    } cmd_e;

    typedef enum logic [REG_WIDTH-1:0] {
        STATUS_IDLE      = 'd0,
        STATUS_RUNNING,
        STATUS_ACCEPTED,
        STATUS_REJECTED,
        STATUS_ERROR
    } status_e;

    // any other opcode value is an error
    typedef enum logic [7:0] {
        OP_CHAR   = 8'h01,
        OP_ANY    = 8'h02,
        OP_JUMP   = 8'h03,
        OP_ACCEPT = 8'h04,
        OP_END    = 8'h05
    } opcode_e;

    typedef struct packed {
        opcode_e    opcode;     // upper byte
        logic [7:0] operand;    // char or jump target
    } instr_t;

    typedef struct packed {
        cmd_e                 cmd;
        logic [REG_WIDTH-1:0] address;
        logic [REG_WIDTH-1:0] data_in;
        logic [REG_WIDTH-1:0] start_cc_pointer;
    } cmd_regs_t;

    typedef struct packed {
        logic accept;
        logic error;
    } coproc_result_t;

endpackage
